/* design/approx_mult_8x8.sv */
module approx_mult_8x8
    import approx_mult_pkg::*;
#(
    parameter int APPROX_BITS       = DEFAULT_APPROX_BITS,
    parameter int INNER_APPROX_BITS = DEFAULT_INNER_APPROX_BITS
) (
    input  operand_t a,
    input  operand_t b,
    output product_t p
);

    nibble_t a_h;
    nibble_t b_h;
    nibble_t a_l;
    nibble_t b_l;

    nibble_prod_t p_hh;
    nibble_prod_t p_hl;
    nibble_prod_t p_lh;
    nibble_prod_t p_ll;

    logic [11:0] operand_one;
    logic [8:0]  operand_two;
    logic [12:0] final_sum;

    assign a_h = a[7:4];
    assign b_h = b[7:4];
    assign a_l = a[3:0];
    assign b_l = b[3:0];

    // ~~~~~~~~~~~~~~~~~~~~
    // nibble products.
    // ~~~~~~~~~~~~~~~~~~~~

    // only high x high goes through the recursive block.
    rec_mult_4x4 #(
        .APPROX_BITS (INNER_APPROX_BITS)
    ) i_mult_hh (
        .a (a_h),
        .b (b_h),
        .p (p_hh)
    );

    assign p_hl = nibble_prod_t'(a_h) * nibble_prod_t'(b_l);
    assign p_lh = nibble_prod_t'(a_l) * nibble_prod_t'(b_h);
    assign p_ll = nibble_prod_t'(a_l) * nibble_prod_t'(b_l);

    // ~~~~~~~~~~~~~~~~~~~~
    // summation.
    // ~~~~~~~~~~~~~~~~~~~~

    assign operand_one = {p_hh, p_ll[7:4]};

    // cross terms summed exactly.
    loa_adder #(
        .A_WIDTH     (8),
        .B_WIDTH     (8),
        .APPROX_BITS (0)
    ) i_mid_adder (
        .a   (p_hl),
        .b   (p_lh),
        .sum (operand_two)
    );

    loa_adder #(
        .A_WIDTH     (12),
        .B_WIDTH     (9),
        .APPROX_BITS (APPROX_BITS)
    ) i_final_adder (
        .a   (operand_one),
        .b   (operand_two),
        .sum (final_sum)
    );

    // the top carry of the final sum falls outside 16 bits.
    assign p = {final_sum[11:0], p_ll[3:0]};

endmodule

/* design/approx_mult_pkg.sv */
package approx_mult_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // operand geometry.
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int OPERAND_WIDTH = 8;
    localparam int NIBBLE_WIDTH  = OPERAND_WIDTH / 2;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // full operand and product.
    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // half operands and their products.
    typedef logic [NIBBLE_WIDTH-1:0]   nibble_t;
    typedef logic [2*NIBBLE_WIDTH-1:0] nibble_prod_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // approximation defaults.
    // ~~~~~~~~~~~~~~~~~~~~

    // low bits OR-approximated in the final 12-bit adder.
    localparam int DEFAULT_APPROX_BITS = 3;

    // adders inside the recursive 4x4 and 3x3 blocks.
    // the 3x3 middle adder is only 2 bits wide, so at most 1 here.
    localparam int DEFAULT_INNER_APPROX_BITS = 0;

endpackage

/* design/approx_mult_unit.sv */
module approx_mult_unit
    import approx_mult_pkg::*;
#(
    parameter int APPROX_BITS       = DEFAULT_APPROX_BITS,
    parameter int INNER_APPROX_BITS = DEFAULT_INNER_APPROX_BITS
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output logic     result_valid,
    output product_t p
);

    operand_t a_q;
    operand_t b_q;
    logic     stage_valid;
    product_t product;

    // ~~~~~~~~~~~~~~~~~~~~
    // stage 1 operand registers.
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q <= a;
            b_q <= b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    approx_mult_8x8 #(
        .APPROX_BITS       (APPROX_BITS),
        .INNER_APPROX_BITS (INNER_APPROX_BITS)
    ) i_mult (
        .a (a_q),
        .b (b_q),
        .p (product)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // stage 2 product register.
    // ~~~~~~~~~~~~~~~~~~~~

    // p keeps the last result between strobes.
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            p            <= '0;
        end else begin
            result_valid <= stage_valid;
            if (stage_valid) begin
                p <= product;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~

    // fixed two-cycle latency with nothing dropped or invented.
    a_latency: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> ##2 result_valid);

    a_no_spurious: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $past(in_valid, 2));

    a_p_hold: assert property (@(posedge clk) disable iff (reset)
        !result_valid |-> $stable(p));

    // a zero operand must survive the approximation as a zero product.
    a_zero_operand: assert property (@(posedge clk) disable iff (reset)
        stage_valid && (a_q == '0 || b_q == '0) |=> p == '0);

endmodule

/* design/loa_adder.sv */
module loa_adder #(
    parameter int A_WIDTH     = 8,
    parameter int B_WIDTH     = 8,
    parameter int APPROX_BITS = 0
) (
    input  logic [A_WIDTH-1:0] a,
    input  logic [B_WIDTH-1:0] b,
    output logic [A_WIDTH:0]   sum
);

    localparam int UPPER_WIDTH = A_WIDTH - APPROX_BITS;

    logic [A_WIDTH-1:0] b_ext;

    // narrower operand zero-extended.
    assign b_ext = A_WIDTH'(b);

    if (B_WIDTH > A_WIDTH) begin : g_bad_width
        $error("loa_adder: B_WIDTH %0d exceeds A_WIDTH %0d", B_WIDTH, A_WIDTH);
    end

    if (APPROX_BITS < 0 || APPROX_BITS >= B_WIDTH) begin : g_bad_approx
        $error("loa_adder: APPROX_BITS %0d out of range for B_WIDTH %0d",
               APPROX_BITS, B_WIDTH);
    end

    if (APPROX_BITS == 0) begin : g_exact
        assign sum = {1'b0, a} + {1'b0, b_ext};
    end else begin : g_loa
        logic [APPROX_BITS-1:0] low_or;
        logic                   carry_in;
        logic [UPPER_WIDTH:0]   upper_sum;

        // lower part ORed in place of added.
        assign low_or = a[APPROX_BITS-1:0] | b_ext[APPROX_BITS-1:0];

        // carry guessed from the top approximated bit pair.
        assign carry_in = a[APPROX_BITS-1] & b_ext[APPROX_BITS-1];

        // exact upper part.
        assign upper_sum = {1'b0, a[A_WIDTH-1:APPROX_BITS]}
                         + {1'b0, b_ext[A_WIDTH-1:APPROX_BITS]}
                         + {{UPPER_WIDTH{1'b0}}, carry_in};

        assign sum = {upper_sum, low_or};
    end

endmodule

/* design/rec_mult_3x3.sv */
module rec_mult_3x3
    import approx_mult_pkg::*;
#(
    parameter int APPROX_BITS = DEFAULT_INNER_APPROX_BITS
) (
    input  logic [2:0] a,
    input  logic [2:0] b,
    output logic [5:0] p
);

    logic       a_h;
    logic       b_h;
    logic [1:0] a_l;
    logic [1:0] b_l;

    logic       p_hh;
    logic [1:0] p_hl;
    logic [1:0] p_lh;
    logic [3:0] p_ll;

    logic [2:0] operand_one;
    logic [2:0] operand_two;
    logic [3:0] final_sum;

    // 1-bit top, 2-bit bottom.
    assign a_h = a[2];
    assign b_h = b[2];
    assign a_l = a[1:0];
    assign b_l = b[1:0];

    // ~~~~~~~~~~~~~~~~~~~~
    // partial products.
    // ~~~~~~~~~~~~~~~~~~~~

    assign p_hh = a_h & b_h;
    assign p_hl = b_l & {2{a_h}};
    assign p_lh = a_l & {2{b_h}};
    assign p_ll = 4'(a_l) * 4'(b_l);

    // hh sits directly above the upper half of ll.
    assign operand_one = {p_hh, p_ll[3:2]};

    loa_adder #(
        .A_WIDTH     (2),
        .B_WIDTH     (2),
        .APPROX_BITS (APPROX_BITS)
    ) i_mid_adder (
        .a   (p_hl),
        .b   (p_lh),
        .sum (operand_two)
    );

    loa_adder #(
        .A_WIDTH     (3),
        .B_WIDTH     (3),
        .APPROX_BITS (APPROX_BITS)
    ) i_final_adder (
        .a   (operand_one),
        .b   (operand_two),
        .sum (final_sum)
    );

    assign p = {final_sum, p_ll[1:0]};

endmodule

/* design/rec_mult_4x4.sv */
module rec_mult_4x4
    import approx_mult_pkg::*;
#(
    parameter int APPROX_BITS = DEFAULT_INNER_APPROX_BITS
) (
    input  nibble_t      a,
    input  nibble_t      b,
    output nibble_prod_t p
);

    logic       a_h;
    logic       b_h;
    logic [2:0] a_l;
    logic [2:0] b_l;

    logic       p_hh;
    logic [2:0] p_hl;
    logic [2:0] p_lh;
    logic [5:0] p_ll;

    logic [3:0] operand_one;
    logic [3:0] operand_two;
    logic [4:0] final_sum;

    // 1-bit top, 3-bit bottom.
    assign a_h = a[3];
    assign b_h = b[3];
    assign a_l = a[2:0];
    assign b_l = b[2:0];

    // ~~~~~~~~~~~~~~~~~~~~
    // partial products.
    // ~~~~~~~~~~~~~~~~~~~~

    assign p_hh = a_h & b_h;
    assign p_hl = b_l & {3{a_h}};
    assign p_lh = a_l & {3{b_h}};

    // low x low recurses one more level.
    rec_mult_3x3 #(
        .APPROX_BITS (APPROX_BITS)
    ) i_mult_ll (
        .a (a_l),
        .b (b_l),
        .p (p_ll)
    );

    assign operand_one = {p_hh, p_ll[5:3]};

    loa_adder #(
        .A_WIDTH     (3),
        .B_WIDTH     (3),
        .APPROX_BITS (APPROX_BITS)
    ) i_mid_adder (
        .a   (p_hl),
        .b   (p_lh),
        .sum (operand_two)
    );

    loa_adder #(
        .A_WIDTH     (4),
        .B_WIDTH     (4),
        .APPROX_BITS (APPROX_BITS)
    ) i_final_adder (
        .a   (operand_one),
        .b   (operand_two),
        .sum (final_sum)
    );

    assign p = {final_sum, p_ll[2:0]};

endmodule

/* files.f */
design/approx_mult_pkg.sv
design/loa_adder.sv
design/rec_mult_3x3.sv
design/rec_mult_4x4.sv
design/approx_mult_8x8.sv
design/approx_mult_unit.sv
testbench/clock_gen.sv
testbench/tb_approx_mult.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_approx_mult \
    -Mdir "$BUILD_DIR" -o sim_approx_mult

"./$BUILD_DIR/sim_approx_mult" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -q "STATUS: FAIL" "$LOG_FILE"; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "STATUS: PASS" "$LOG_FILE"; then
    echo "simulation ended without a result line"
    exit 1
fi

echo "simulation passed"

/* testbench/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* testbench/tb_approx_mult.sv */
module tb_approx_mult
    import approx_mult_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          APPROX_BITS    = 3;
    localparam int          RESULT_TIMEOUT = 20;
    localparam int          RESET_TIMEOUT  = 40;
    localparam logic [31:0] ERROR_BOUND    = 32'd1 << (APPROX_BITS + 4);

    logic        clk;
    logic        reset;
    logic        in_valid;
    operand_t    a;
    operand_t    b;
    logic        result_valid;
    product_t    p;
    logic [15:0] lfsr_state  = 16'd89;
    product_t    last_p      = '0;
    product_t    expected_q[$];

    clock_gen i_clock_gen (.clk(clk), .reset(reset));

    approx_mult_unit i_dut (
        .clk(clk), .reset(reset), .in_valid(in_valid), .a(a), .b(b),
        .result_valid(result_valid), .p(p)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~

    // lower-part OR adder on plain integers.
    function automatic logic [31:0] loa_model(input logic [31:0] x, input logic [31:0] y,
                                              input int k);
        logic [31:0] low;
        logic [31:0] carry;
        logic [31:0] upper;
        if (k == 0) return x + y;
        low   = (x | y) & ((32'd1 << k) - 32'd1);
        carry = (x >> (k - 1)) & (y >> (k - 1)) & 32'd1;
        upper = (x >> k) + (y >> k) + carry;
        return (upper << k) | low;
    endfunction

    // inner adders are exact at the default setting, so hh is a plain product.
    function automatic product_t model_product(input operand_t x, input operand_t y);
        logic [31:0] hh;
        logic [31:0] hl;
        logic [31:0] lh;
        logic [31:0] ll;
        logic [31:0] fsum;
        hh   = 32'(x[7:4]) * 32'(y[7:4]);
        hl   = 32'(x[7:4]) * 32'(y[3:0]);
        lh   = 32'(x[3:0]) * 32'(y[7:4]);
        ll   = 32'(x[3:0]) * 32'(y[3:0]);
        fsum = loa_model((hh << 4) | (ll >> 4), loa_model(hl, lh, 0), APPROX_BITS);
        return product_t'(((fsum & 32'hFFF) << 4) | (ll & 32'hF));
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // checking and waiting.
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic timeout_failure(input string what);
        $display("timed out waiting for %s", what);
        $display("STATUS: FAIL");
        $fatal(1, "stopping on timeout");
    endtask

    // p must hold while result_valid is low.
    task automatic wait_result(output int waited);
        logic found;
        found  = 1'b0;
        waited = 0;
        while (!found) begin
            @(negedge clk);
            waited++;
            if (result_valid) begin
                found = 1'b1;
            end else begin
                check_value("p_hold", 32'(p), 32'(last_p));
                if (waited >= RESULT_TIMEOUT) timeout_failure("result_valid");
            end
        end
        last_p = p;
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("result_valid", 32'(result_valid), 32'd0);
            check_value("p_hold", 32'(p), 32'(last_p));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // tests.
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset();
        logic in_reset;
        int   cycles;
        in_reset = 1'b1;
        cycles   = 0;
        while (in_reset) begin
            @(negedge clk);
            cycles++;
            check_value("result_valid", 32'(result_valid), 32'd0);
            check_value("p", 32'(p), 32'd0);
            in_reset = reset;
            if (in_reset && cycles >= RESET_TIMEOUT) timeout_failure("reset release");
        end
        last_p = '0;
        expect_idle(3);
    endtask

    task automatic run_single(input operand_t x, input operand_t y, output product_t got);
        int waited;
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= x;
        b        <= y;
        @(posedge clk);
        in_valid <= 1'b0;
        wait_result(waited);
        // first negedge after the strobe cycle is cycle n+1.
        check_value("latency", 32'(waited), 32'd2);
        check_value("p", 32'(p), 32'(model_product(x, y)));
        got = p;
    endtask

    task automatic test_corners();
        product_t got;
        run_single(8'h00, 8'h00, got);
        run_single(8'h00, 8'hA5, got);
        run_single(8'hFF, 8'hFF, got);
        run_single(8'h01, 8'h5A, got);
        run_single(8'h37, 8'h01, got);
        run_single(8'h10, 8'h10, got);
        run_single(8'h0F, 8'h0F, got);
    endtask

    task automatic test_random_pairs(input int count);
        operand_t    x;
        operand_t    y;
        product_t    got;
        logic [31:0] exact;
        logic [31:0] diff;
        for (int i = 0; i < count; i++) begin
            x = operand_t'(random_bits(8));
            y = operand_t'(random_bits(8));
            run_single(x, y, got);
            exact = 32'(x) * 32'(y);
            diff  = (exact > 32'(got)) ? exact - 32'(got) : 32'(got) - exact;
            check_value("error_below_bound", 32'(diff < ERROR_BOUND), 32'd1);
        end
    endtask

    // back-to-back strobes unless with_gaps adds idle gaps of 0 to 3.
    task automatic test_stream(input int count, input logic with_gaps);
        operand_t x;
        operand_t y;
        int       gap;
        int       waited;
        fork
            begin
                for (int i = 0; i < count; i++) begin
                    x = operand_t'(random_bits(8));
                    y = operand_t'(random_bits(8));
                    @(posedge clk);
                    in_valid <= 1'b1;
                    a        <= x;
                    b        <= y;
                    expected_q.push_back(model_product(x, y));
                    gap = with_gaps ? int'(random_bits(2)) : 0;
                    if (gap > 0) begin
                        @(posedge clk);
                        in_valid <= 1'b0;
                        repeat (gap - 1) @(posedge clk);
                    end
                end
                @(posedge clk);
                in_valid <= 1'b0;
            end
            begin
                for (int i = 0; i < count; i++) begin
                    wait_result(waited);
                    if (!with_gaps && i > 0) check_value("back_to_back", 32'(waited), 32'd1);
                    check_value("p", 32'(p), 32'(expected_q.pop_front()));
                end
            end
        join
        expect_idle(4);
    endtask

    initial begin
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        test_reset();
        test_corners();
        test_random_pairs(256);
        test_stream(64, 1'b0);
        test_stream(48, 1'b1);
        $display("STATUS: PASS");
        $finish;
    end

endmodule
